//--- flist.f
+incdir+hw
hw/mmu_pkg.sv
hw/tlb_if.sv
hw/cp0_tlb_if.sv
hw/tlb_array.sv
hw/tlb_random_counter.sv
hw/mmu_cp0_regs.sv
hw/mmu_data.sv
hw/mmu_control_fsm.sv
hw/mmu_top.sv
verification/mmu_tb.sv

//--- hw/cp0_tlb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cp0_tlb_if ();

    // Current register values.
    logic [31:0] index;
    logic [31:0] entryhi;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;

    // TLBP result.
    logic        probe_we;
    logic [31:0] probe_index_value;

    // TLBR result.
    logic        read_we;
    logic [31:0] read_entryhi;
    logic [31:0] read_entrylo0;
    logic [31:0] read_entrylo1;

    modport register (
        output index, entryhi, entrylo0, entrylo1,
        input  probe_we, probe_index_value,
        input  read_we, read_entryhi, read_entrylo0, read_entrylo1
    );

    modport user (
        input  index, entryhi, entrylo0, entrylo1,
        output probe_we, probe_index_value,
        output read_we, read_entryhi, read_entrylo0, read_entrylo1
    );

endinterface

`default_nettype wire

//--- hw/mmu_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_control_fsm import mmu_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          req_valid,
    output logic         req_ready,
    input  wire  [31:0]  req_vaddr,
    input  wire          req_store,
    output logic         resp_valid,
    input  wire          resp_ready,
    input  wire          op_valid,
    output logic         op_ready,
    input  tlb_op_t      op_code_in,
    output logic         op_done,
    output logic [31:0]  vaddr,
    output logic         store,
    output logic         do_search,
    output tlb_op_t      op_code,
    output logic         op_fire
);

    typedef enum logic [1:0] {
        st_idle,
        st_respond,
        st_operate
    } state_t;

    state_t state;
    logic   resp_valid_q;
    logic   op_accept;
    logic   req_accept;

    assign op_ready   = (state == st_idle);
    assign req_ready  = (state == st_idle) && !op_valid; // Operations win a tie.
    assign op_accept  = op_valid && op_ready;
    assign req_accept = req_valid && req_ready;

    // The first respond cycle is the lookup, the response is valid from the next edge on.
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            resp_valid_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (op_accept) state <= st_operate;
                    else if (req_accept) state <= st_respond;
                end
                st_respond: begin
                    if (resp_valid_q && resp_ready) begin
                        state        <= st_idle;
                        resp_valid_q <= 1'b0;
                    end else begin
                        resp_valid_q <= 1'b1;
                    end
                end
                st_operate: state <= st_idle; // Single execute cycle.
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            vaddr <= req_vaddr;
            store <= req_store;
        end
        if (op_accept) op_code <= op_code_in;
    end

    assign resp_valid = resp_valid_q;
    assign do_search  = (state == st_respond) && !resp_valid_q;
    assign op_fire    = (state == st_operate);
    assign op_done    = (state == st_operate);

endmodule

`default_nettype wire

//--- hw/mmu_cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_cp0_regs import mmu_pkg::*; (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            cp0_we,
    input  cp0_sel_t                       cp0_sel,
    input  wire  [31:0]                    cp0_wdata,
    output logic [31:0]                    cp0_rdata,
    input  wire  [`MMU_TLB_INDEX_W-1:0]    random_index,
    cp0_tlb_if.register                    cp0
);

    localparam logic [31:0] INDEX_MASK   = 32'h8000_0000 | 32'(`MMU_TLBNUM - 1);
    localparam logic [31:0] ENTRYHI_MASK = 32'hFFFF_E0FF; // VPN2 and ASID.
    localparam logic [31:0] ENTRYLO_MASK = 32'h03FF_FFFF; // PFN, C, D, V, G.

    logic [31:0] index_q;
    logic [31:0] entryhi_q;
    logic [31:0] entrylo0_q;
    logic [31:0] entrylo1_q;

    // TLB instruction write-back takes priority over a software write in the same cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            index_q    <= '0;
            entryhi_q  <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
        end else begin
            if (cp0.probe_we) begin
                index_q <= cp0.probe_index_value & INDEX_MASK;
            end else if (cp0_we && cp0_sel == sel_index) begin
                index_q <= cp0_wdata & INDEX_MASK;
            end

            if (cp0.read_we) begin
                entryhi_q  <= cp0.read_entryhi & ENTRYHI_MASK;
                entrylo0_q <= cp0.read_entrylo0 & ENTRYLO_MASK;
                entrylo1_q <= cp0.read_entrylo1 & ENTRYLO_MASK;
            end else if (cp0_we) begin
                if (cp0_sel == sel_entryhi) entryhi_q <= cp0_wdata & ENTRYHI_MASK;
                if (cp0_sel == sel_entrylo0) entrylo0_q <= cp0_wdata & ENTRYLO_MASK;
                if (cp0_sel == sel_entrylo1) entrylo1_q <= cp0_wdata & ENTRYLO_MASK;
            end
        end
    end

    assign cp0.index    = index_q;
    assign cp0.entryhi  = entryhi_q;
    assign cp0.entrylo0 = entrylo0_q;
    assign cp0.entrylo1 = entrylo1_q;

    always_comb begin
        case (cp0_sel)
            sel_index:    cp0_rdata = index_q;
            sel_entryhi:  cp0_rdata = entryhi_q;
            sel_entrylo0: cp0_rdata = entrylo0_q;
            sel_entrylo1: cp0_rdata = entrylo1_q;
            sel_random:   cp0_rdata = 32'(random_index); // Read-only.
            default:      cp0_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mmu_data.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_data import mmu_pkg::*; (
    input  wire  [31:0]                    vaddr,
    input  wire                            store,
    input  wire                            do_search,
    input  tlb_op_t                        op_code,
    input  wire                            op_fire,
    input  wire  [`MMU_TLB_INDEX_W-1:0]    random_index,
    output logic [31:0]                    paddr,
    output mmu_exc_t                       exc,
    tlb_if.client                          tlb,
    cp0_tlb_if.user                        cp0
);

    localparam int VPN2_LSB = 32 - `MMU_VPN2_W;

    logic       direct;
    logic       is_tlbp;
    logic       is_tlbr;
    logic       is_tlbwi;
    logic       is_tlbwr;
    tlb_entry_t packed_entry;

    assign is_tlbp  = op_fire && (op_code == op_tlbp);
    assign is_tlbr  = op_fire && (op_code == op_tlbr);
    assign is_tlbwi = op_fire && (op_code == op_tlbwi);
    assign is_tlbwr = op_fire && (op_code == op_tlbwr);

    assign direct = (vaddr[31:30] == 2'b10); // kseg0 and kseg1.

    // TLBP probes with EntryHi. Translations use the address.
    assign tlb.s_vpn2 = is_tlbp ? cp0.entryhi[31:VPN2_LSB] : vaddr[31:VPN2_LSB];
    assign tlb.s_odd  = vaddr[`MMU_OFFSET_W];
    assign tlb.s_asid = cp0.entryhi[`MMU_ASID_W-1:0];

    assign paddr = direct ? {3'b000, vaddr[28:0]}
                          : {tlb.s_pfn, vaddr[`MMU_OFFSET_W-1:0]};

    always_comb begin
        if (!do_search || direct) begin
            exc = exc_none;
        end else if (!tlb.s_found) begin
            exc = store ? exc_refill_store : exc_refill_load;
        end else if (!tlb.s_v) begin
            exc = store ? exc_invalid_store : exc_invalid_load;
        end else if (store && !tlb.s_d) begin
            exc = exc_modify;
        end else begin
            exc = exc_none;
        end
    end

    // EntryLo layout is {pfn, c, d, v, g} from bit 25 down to bit 0.
    always_comb begin
        packed_entry.vpn2 = cp0.entryhi[31:VPN2_LSB];
        packed_entry.asid = cp0.entryhi[`MMU_ASID_W-1:0];
        packed_entry.g    = cp0.entrylo0[0] & cp0.entrylo1[0];
        packed_entry.pfn0 = cp0.entrylo0[25:6];
        packed_entry.c0   = cp0.entrylo0[5:3];
        packed_entry.d0   = cp0.entrylo0[2];
        packed_entry.v0   = cp0.entrylo0[1];
        packed_entry.pfn1 = cp0.entrylo1[25:6];
        packed_entry.c1   = cp0.entrylo1[5:3];
        packed_entry.d1   = cp0.entrylo1[2];
        packed_entry.v1   = cp0.entrylo1[1];
    end

    assign tlb.we      = is_tlbwi || is_tlbwr;
    assign tlb.w_index = is_tlbwr ? random_index : cp0.index[`MMU_TLB_INDEX_W-1:0];
    assign tlb.w_entry = packed_entry;
    assign tlb.r_index = cp0.index[`MMU_TLB_INDEX_W-1:0];

    // Probe result. Bit 31 flags a miss.
    assign cp0.probe_we          = is_tlbp;
    assign cp0.probe_index_value = {~tlb.s_found, {(31 - `MMU_TLB_INDEX_W){1'b0}},
                                    tlb.s_index};

    assign cp0.read_we       = is_tlbr;
    assign cp0.read_entryhi  = {tlb.r_entry.vpn2, 5'b0, tlb.r_entry.asid};
    assign cp0.read_entrylo0 = {6'b0, tlb.r_entry.pfn0, tlb.r_entry.c0,
                                tlb.r_entry.d0, tlb.r_entry.v0, tlb.r_entry.g};
    assign cp0.read_entrylo1 = {6'b0, tlb.r_entry.pfn1, tlb.r_entry.c1,
                                tlb.r_entry.d1, tlb.r_entry.v1, tlb.r_entry.g};

endmodule

`default_nettype wire

//--- hw/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Number of TLB entries and the width of an index into them.
`define MMU_TLBNUM 16
`define MMU_TLB_INDEX_W 4

// Fixed 4 KiB pages. One entry maps an even/odd page pair.
`define MMU_VPN2_W 19
`define MMU_PFN_W 20
`define MMU_OFFSET_W 12

`define MMU_ASID_W 8

`endif

//--- hw/mmu_pkg.sv
`default_nettype none

`include "mmu_params.svh"

package mmu_pkg;

    // One dual-page TLB entry. Page 0 is the even page, page 1 the odd one.
    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;
        logic [`MMU_PFN_W-1:0]  pfn0;
        logic [2:0]             c0;
        logic                   d0;
        logic                   v0;
        logic [`MMU_PFN_W-1:0]  pfn1;
        logic [2:0]             c1;
        logic                   d1;
        logic                   v1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        exc_none,
        exc_refill_load,
        exc_refill_store,
        exc_invalid_load,
        exc_invalid_store,
        exc_modify
    } mmu_exc_t;

    typedef enum logic [1:0] {
        op_tlbp,
        op_tlbr,
        op_tlbwi,
        op_tlbwr
    } tlb_op_t;

    typedef enum logic [2:0] {
        sel_index,
        sel_entryhi,
        sel_entrylo0,
        sel_entrylo1,
        sel_random
    } cp0_sel_t;

endpackage

`default_nettype wire

//--- hw/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_top import mmu_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          req_valid,
    output logic         req_ready,
    input  wire  [31:0]  req_vaddr,
    input  wire          req_store,
    output logic         resp_valid,
    input  wire          resp_ready,
    output logic [31:0]  resp_paddr,
    output mmu_exc_t     resp_exc,
    input  wire          op_valid,
    output logic         op_ready,
    input  tlb_op_t      op_code,
    output logic         op_done,
    input  wire          cp0_we,
    input  cp0_sel_t     cp0_sel,
    input  wire  [31:0]  cp0_wdata,
    output logic [31:0]  cp0_rdata
);

    logic [31:0]                 vaddr;
    logic                        store;
    logic                        do_search;
    tlb_op_t                     op_code_q;
    logic                        op_fire;
    logic [31:0]                 paddr;
    mmu_exc_t                    exc;
    logic [`MMU_TLB_INDEX_W-1:0] random_index;

    tlb_if     tlb_bus ();
    cp0_tlb_if cp0_bus ();

    mmu_control_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_vaddr  (req_vaddr),
        .req_store  (req_store),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .op_code_in (op_code),
        .op_done    (op_done),
        .vaddr      (vaddr),
        .store      (store),
        .do_search  (do_search),
        .op_code    (op_code_q),
        .op_fire    (op_fire)
    );

    mmu_data u_data (
        .vaddr        (vaddr),
        .store        (store),
        .do_search    (do_search),
        .op_code      (op_code_q),
        .op_fire      (op_fire),
        .random_index (random_index),
        .paddr        (paddr),
        .exc          (exc),
        .tlb          (tlb_bus.client),
        .cp0          (cp0_bus.user)
    );

    tlb_array u_tlb (
        .clk   (clk),
        .reset (reset),
        .tlb   (tlb_bus.array)
    );

    tlb_random_counter u_random (
        .clk          (clk),
        .reset        (reset),
        .random_index (random_index)
    );

    mmu_cp0_regs u_cp0 (
        .clk          (clk),
        .reset        (reset),
        .cp0_we       (cp0_we),
        .cp0_sel      (cp0_sel),
        .cp0_wdata    (cp0_wdata),
        .cp0_rdata    (cp0_rdata),
        .random_index (random_index),
        .cp0          (cp0_bus.register)
    );

    // Response is latched at the end of the lookup cycle and held under back-pressure.
    always_ff @(posedge clk) begin
        if (do_search) begin
            resp_paddr <= paddr;
            resp_exc   <= exc;
        end
    end

endmodule

`default_nettype wire

//--- hw/tlb_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_array import mmu_pkg::*; (
    input  wire   clk,
    input  wire   reset,
    tlb_if.array  tlb
);

    tlb_entry_t                  entries [`MMU_TLBNUM];
    logic [`MMU_TLBNUM-1:0]      match;
    logic                        hit;
    logic [`MMU_TLB_INDEX_W-1:0] hit_index;
    tlb_entry_t                  hit_entry;

    // Only the valid bits are cleared, the rest of each entry is don't-care until written.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MMU_TLBNUM; i++) begin
                entries[i].v0 <= 1'b0;
                entries[i].v1 <= 1'b0;
            end
        end else if (tlb.we) begin
            entries[tlb.w_index] <= tlb.w_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            match[i] = (entries[i].vpn2 == tlb.s_vpn2) &&
                       (entries[i].g || (entries[i].asid == tlb.s_asid));
        end
    end

    // Lowest matching entry wins. Software should never create duplicates anyway.
    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            if (!hit && match[i]) begin
                hit       = 1'b1;
                hit_index = `MMU_TLB_INDEX_W'(i);
            end
        end
    end

    assign hit_entry = entries[hit_index];

    assign tlb.s_found = hit;
    assign tlb.s_index = hit_index;
    assign tlb.s_pfn   = tlb.s_odd ? hit_entry.pfn1 : hit_entry.pfn0;
    assign tlb.s_c     = tlb.s_odd ? hit_entry.c1   : hit_entry.c0;
    assign tlb.s_d     = tlb.s_odd ? hit_entry.d1   : hit_entry.d0;
    assign tlb.s_v     = tlb.s_odd ? hit_entry.v1   : hit_entry.v0;

    assign tlb.r_entry = entries[tlb.r_index]; // Indexed read for TLBR.

endmodule

`default_nettype wire

//--- hw/tlb_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

interface tlb_if import mmu_pkg::*; ();

    logic [`MMU_VPN2_W-1:0]      s_vpn2;
    logic                        s_odd;
    logic [`MMU_ASID_W-1:0]      s_asid;
    logic                        s_found;
    logic [`MMU_TLB_INDEX_W-1:0] s_index;
    logic [`MMU_PFN_W-1:0]       s_pfn;
    logic [2:0]                  s_c;
    logic                        s_d;
    logic                        s_v;

    logic [`MMU_TLB_INDEX_W-1:0] r_index;
    tlb_entry_t                  r_entry;

    logic                        we;
    logic [`MMU_TLB_INDEX_W-1:0] w_index;
    tlb_entry_t                  w_entry;

    modport array (
        input  s_vpn2, s_odd, s_asid, r_index, we, w_index, w_entry,
        output s_found, s_index, s_pfn, s_c, s_d, s_v, r_entry
    );

    modport client (
        output s_vpn2, s_odd, s_asid, r_index, we, w_index, w_entry,
        input  s_found, s_index, s_pfn, s_c, s_d, s_v, r_entry
    );

endinterface

`default_nettype wire

//--- hw/tlb_random_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_random_counter (
    input  wire                               clk,
    input  wire                               reset,
    output logic [`MMU_TLB_INDEX_W-1:0]       random_index
);

    localparam logic [`MMU_TLB_INDEX_W-1:0] TOP = `MMU_TLB_INDEX_W'(`MMU_TLBNUM - 1);

    // Free-running down-counter. There is no Wired register, so the full range is used.
    always_ff @(posedge clk) begin
        if (reset) begin
            random_index <= TOP;
        end else if (random_index == '0) begin
            random_index <= TOP;
        end else begin
            random_index <= random_index - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module mmu_tb -o mmu_tb_sim 2>&1 | tee build.log
./obj_dir/mmu_tb_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi
exit 0

//--- verification/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_tb import mmu_pkg::*; ();

    localparam int CYCLE_LIMIT = 4000; // Roughly ten times the length of all tests.

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_vaddr;
    logic        req_store;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_paddr;
    mmu_exc_t    resp_exc;
    logic        op_valid;
    logic        op_ready;
    tlb_op_t     op_code;
    logic        op_done;
    logic        cp0_we;
    cp0_sel_t    cp0_sel;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;

    tlb_entry_t  model [`MMU_TLBNUM]; // Expected TLB contents.
    logic [7:0]  cur_asid;
    logic [34:0] expect_q [$];        // {exc, paddr} per outstanding request.
    integer      seed = 24;
    int          errors;
    int          cycles;
    int          tests_passed;
    int          tests_failed;
    int          test_start_errors;
    logic        stall_en;
    logic        hold_active;
    logic [31:0] hold_paddr;
    mmu_exc_t    hold_exc;

    mmu_top UUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Random stretches of back-pressure when enabled.
    always @(negedge clk) begin
        resp_ready = stall_en ? (($random(seed) & 1) == 1) : 1'b1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] lo_word(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    function automatic tlb_entry_t make_entry(input logic [18:0] vpn2, input logic [7:0] asid,
                                              input logic g, input logic d0, input logic v0,
                                              input logic d1, input logic v1);
        tlb_entry_t e;
        e.vpn2 = vpn2;
        e.asid = asid;
        e.g    = g;
        e.pfn0 = 20'($random(seed));
        e.c0   = 3'd3;
        e.d0   = d0;
        e.v0   = v0;
        e.pfn1 = 20'($random(seed));
        e.c1   = 3'd2;
        e.d1   = d1;
        e.v1   = v1;
        return e;
    endfunction

    // Expected {exc, paddr} for one access, from the address mapping rules.
    function automatic logic [34:0] translate_ref(input logic [31:0] addr, input logic store);
        logic [2:0]  exc;
        logic [31:0] pa;
        logic        found;
        logic        odd;
        tlb_entry_t  e;
        exc   = exc_none;
        found = 1'b0;
        odd   = addr[12];
        e     = '0;
        if (addr[31:30] == 2'b10) begin
            pa = {3'b000, addr[28:0]};
        end else begin
            for (int i = 0; i < `MMU_TLBNUM; i++) begin
                if (!found && model[i].vpn2 == addr[31:13] &&
                    (model[i].g || model[i].asid == cur_asid)) begin
                    found = 1'b1;
                    e     = model[i];
                end
            end
            if (!found) exc = store ? exc_refill_store : exc_refill_load;
            else if (!(odd ? e.v1 : e.v0)) exc = store ? exc_invalid_store : exc_invalid_load;
            else if (store && !(odd ? e.d1 : e.d0)) exc = exc_modify;
            pa = {odd ? e.pfn1 : e.pfn0, addr[11:0]};
        end
        return {exc, pa};
    endfunction

    // Expected Index after a probe. Bit 31 flags a miss.
    function automatic logic [31:0] probe_ref(input logic [18:0] vpn2, input logic [7:0] asid);
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            if (model[i].vpn2 == vpn2 && (model[i].g || model[i].asid == asid)) begin
                return 32'(i);
            end
        end
        return 32'h8000_0000;
    endfunction

    // Comparison process. Expected values are taken at request acceptance.
    always @(posedge clk) begin
        logic [34:0] exp;
        if (!reset) begin
            if (hold_active) begin
                check_value("resp_valid", 32'(resp_valid), 32'd1);
                check_value("resp_paddr", resp_paddr, hold_paddr);
                check_value("resp_exc", 32'(resp_exc), 32'(hold_exc));
            end
            hold_active <= resp_valid && !resp_ready;
            hold_paddr  <= resp_paddr;
            hold_exc    <= resp_exc;
            if (resp_valid) check_value("req_ready", 32'(req_ready), 32'd0);
            if (req_valid && req_ready) expect_q.push_back(translate_ref(req_vaddr, req_store));
            if (resp_valid && resp_ready) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("a response arrived with no request outstanding at %0t", $time);
                end else begin
                    exp = expect_q.pop_front();
                    check_value("resp_exc", 32'(resp_exc), 32'(exp[34:32]));
                    if (exp[34:32] == 3'(exc_none)) begin
                        check_value("resp_paddr", resp_paddr, exp[31:0]);
                    end
                end
            end
        end
    end

    task automatic cp0_write(input cp0_sel_t sel, input logic [31:0] data);
        @(negedge clk);
        cp0_we    = 1'b1;
        cp0_sel   = sel;
        cp0_wdata = data;
        @(negedge clk);
        cp0_we = 1'b0;
        if (sel == sel_entryhi) cur_asid = data[7:0];
    endtask

    task automatic cp0_read(input cp0_sel_t sel, output logic [31:0] data);
        @(negedge clk);
        cp0_sel = sel;
        #1 data = cp0_rdata;
    endtask

    task automatic run_op(input tlb_op_t code);
        @(negedge clk);
        op_valid = 1'b1;
        op_code  = code;
        while (!op_ready) @(negedge clk);
        @(negedge clk);
        op_valid = 1'b0;
        check_value("op_done", 32'(op_done), 32'd1); // High in the cycle after acceptance.
        @(negedge clk);
        check_value("op_done", 32'(op_done), 32'd0);
    endtask

    task automatic send_req(input logic [31:0] addr, input logic store);
        @(negedge clk);
        req_valid = 1'b1;
        req_vaddr = addr;
        req_store = store;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain_responses();
        while (expect_q.size() != 0) @(negedge clk);
    endtask

    task automatic write_entry(input int idx, input tlb_entry_t e);
        cp0_write(sel_index, 32'(idx));
        cp0_write(sel_entryhi, {e.vpn2, 5'b0, e.asid});
        cp0_write(sel_entrylo0, lo_word(e.pfn0, e.c0, e.d0, e.v0, e.g));
        cp0_write(sel_entrylo1, lo_word(e.pfn1, e.c1, e.d1, e.v1, e.g));
        run_op(op_tlbwi);
        model[idx] = e;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd;
        logic [18:0] pages [5];
        tlb_entry_t  e;
        pages = '{19'h00100, 19'h00200, 19'h00300, 19'h00400, 19'h00600};
        reset = 1'b1;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_store = 1'b0;
        op_valid = 1'b0;
        op_code = op_tlbp;
        cp0_we = 1'b0;
        cp0_sel = sel_index;
        cp0_wdata = '0;
        resp_ready = 1'b1;
        stall_en = 1'b0;
        hold_active = 1'b0;
        cur_asid = '0;
        errors = 0;
        cycles = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_start_errors = 0;
        for (int i = 0; i < `MMU_TLBNUM; i++) model[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        cp0_sel = sel_random;
        #1;

        check_value("req_ready", 32'(req_ready), 32'd1);
        check_value("op_ready", 32'(op_ready), 32'd1);
        check_value("resp_valid", 32'(resp_valid), 32'd0);
        check_value("op_done", 32'(op_done), 32'd0);
        check_value("random", cp0_rdata, 32'(`MMU_TLBNUM - 1));
        cp0_read(sel_random, rd);
        check_value("random", rd, 32'(`MMU_TLBNUM - 2)); // One decrement per cycle.
        cp0_read(sel_index, rd);
        check_value("index", rd, 32'd0);
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            send_req({2'b10, rnd[29:0]}, rnd[30]);
        end
        drain_responses();
        finish_test("direct_mapping");

        // Fill every entry so no stale contents can match, then place the mappings.
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            write_entry(i, make_entry(19'h7FF00 + 19'(i), 8'hEE, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        end
        write_entry(2, make_entry(19'h00100, 8'h11, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
        write_entry(5, make_entry(19'h00200, 8'h33, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
        write_entry(9, make_entry(19'h00300, 8'h11, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
        write_entry(12, make_entry(19'h00400, 8'h22, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
        cp0_write(sel_entryhi, 32'h0000_0011);
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            send_req({pages[rnd[0]], rnd[1], rnd[13:2]}, rnd[14]);
        end
        drain_responses();
        finish_test("mapped_translation");

        send_req({19'h00600, 1'b0, 12'h123}, 1'b0); // Refill on load.
        send_req({19'h00600, 1'b1, 12'h456}, 1'b1); // Refill on store.
        send_req({19'h00400, 1'b0, 12'h010}, 1'b0); // ASID mismatch.
        send_req({19'h00300, 1'b0, 12'h020}, 1'b0); // Invalid.
        send_req({19'h00300, 1'b0, 12'h030}, 1'b1);
        send_req({19'h00300, 1'b1, 12'h040}, 1'b1); // Modify.
        send_req({19'h00300, 1'b1, 12'h050}, 1'b0); // Load to a clean page is fine.
        drain_responses();
        finish_test("exceptions");

        cp0_write(sel_entryhi, {19'h00100, 5'b0, 8'h11});
        run_op(op_tlbp);
        cp0_read(sel_index, rd);
        check_value("index", rd, probe_ref(19'h00100, 8'h11));
        cp0_write(sel_entryhi, {19'h00200, 5'b0, 8'h77}); // Global entry ignores ASID.
        run_op(op_tlbp);
        cp0_read(sel_index, rd);
        check_value("index", rd, probe_ref(19'h00200, 8'h77));
        cp0_write(sel_entryhi, {19'h00600, 5'b0, 8'h11});
        run_op(op_tlbp);
        cp0_read(sel_index, rd);
        check_value("index[31]", 32'(rd[31]), 32'd1);
        cp0_write(sel_index, 32'd9);
        run_op(op_tlbr);
        e = model[9];
        cp0_read(sel_entryhi, rd);
        check_value("entryhi", rd, {e.vpn2, 5'b0, e.asid});
        cp0_read(sel_entrylo0, rd);
        check_value("entrylo0", rd, lo_word(e.pfn0, e.c0, e.d0, e.v0, e.g));
        cp0_read(sel_entrylo1, rd);
        check_value("entrylo1", rd, lo_word(e.pfn1, e.c1, e.d1, e.v1, e.g));
        cur_asid = e.asid;
        finish_test("tlbp_tlbr");

        stall_en = 1'b1;
        for (int i = 0; i < 30; i++) begin
            rnd = $random(seed);
            send_req({pages[rnd[2:0] % 5], rnd[3], rnd[15:4]}, rnd[16]);
        end
        drain_responses();
        stall_en = 1'b0;
        finish_test("back_pressure");

        e = make_entry(19'h00500, 8'h11, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
        cp0_write(sel_entryhi, {e.vpn2, 5'b0, e.asid});
        cp0_write(sel_entrylo0, lo_word(e.pfn0, e.c0, e.d0, e.v0, e.g));
        cp0_write(sel_entrylo1, lo_word(e.pfn1, e.c1, e.d1, e.v1, e.g));
        run_op(op_tlbwr);
        run_op(op_tlbp);
        cp0_read(sel_index, rd);
        check_value("index[31]", 32'(rd[31]), 32'd0);
        if (rd[30:0] >= 31'(`MMU_TLBNUM)) begin
            errors++;
            $display("probe after TLBWR returned an index outside the TLB");
        end
        model[rd[3:0]] = e;
        send_req({19'h00500, 1'b0, 12'h2A4}, 1'b0);
        send_req({19'h00500, 1'b1, 12'h7F0}, 1'b1);
        drain_responses();
        finish_test("tlbwr");

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
